// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module decode_stage_tb -Mdir "$build_dir" -f src.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vdecode_stage_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: PASSED" "$log_file"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $log_file"
    exit 1
fi

// File: sim/decode_stage_chk.sv
`timescale 1ns/1ps

module decode_stage_chk import rv_decode_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         instr_valid,
    input logic         ctrl_valid,
    input ctrl_bundle_t ctrl
);

    // One memory access per instruction
    a_mem_excl: assert property (@(posedge clk) !(ctrl.mem_we && ctrl.mem_rd))
        else $error("mem_we and mem_rd high together");

    a_ans_md: assert property (@(posedge clk) ctrl.ans_sel |-> ctrl.ccu_mode[7:3] == 5'b01000)
        else $error("ans_sel set outside the mul/div modes");

    a_reset_clear: assert property (@(posedge clk) reset |=> !ctrl_valid)
        else $error("ctrl_valid high in the cycle after reset");

    // Exactly one cycle of latency
    a_valid_follow: assert property (@(posedge clk)
        !$past(reset) |-> ctrl_valid == $past(instr_valid))
        else $error("ctrl_valid does not follow instr_valid");

endmodule

bind decode_stage decode_stage_chk chk0 (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .ctrl_valid  (ctrl_valid),
    .ctrl        (ctrl)
);

// File: sim/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import rv_decode_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int idle_cycles  = 16;

    logic         clk;
    logic         reset;
    logic         instr_valid;
    instr_t       instr;
    logic         ctrl_valid;
    ctrl_bundle_t ctrl;

    logic [127:0] vec_tag[$];
    instr_t       vec_instr[$];
    ctrl_bundle_t vec_exp[$];
    int           pending[$];      // Vector indices held in the decode register

    int          vec_count;
    int          error_count;
    int          pass_count;
    int          fail_count;
    bit          test_ok;
    bit          vectors_loaded;
    logic [31:0] lcg_state;

    decode_stage dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Budget scales with the vector count
    initial begin
        wait (vectors_loaded);
        #(clk_period * (vec_count + 40) * 2);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic note_error();
        error_count++;
        test_ok = 1'b0;
    endtask

    task automatic check_ccu(input ccu_mode_e got, input ccu_mode_e want);
        if (got !== want) begin
            $display("[ERROR] ctrl.ccu_mode got 0x%02h expected 0x%02h", got, want);
            note_error();
        end
    endtask

    task automatic check_jump(input jump_e got, input jump_e want);
        if (got !== want) begin
            $display("[ERROR] ctrl.jump got 0x%01h expected 0x%01h", got, want);
            note_error();
        end
    endtask

    task automatic check_width(input mem_width_e got, input mem_width_e want);
        if (got !== want) begin
            $display("[ERROR] ctrl.mem_width got 0x%01h expected 0x%01h", got, want);
            note_error();
        end
    endtask

    task automatic check_src_a(input src_a_sel_e got, input src_a_sel_e want);
        if (got !== want) begin
            $display("[ERROR] ctrl.src_a_sel got 0x%01h expected 0x%01h", got, want);
            note_error();
        end
    endtask

    task automatic check_src_b(input src_b_sel_e got, input src_b_sel_e want);
        if (got !== want) begin
            $display("[ERROR] ctrl.src_b_sel got 0x%01h expected 0x%01h", got, want);
            note_error();
        end
    endtask

    task automatic check_wb(input wb_sel_e got, input wb_sel_e want);
        if (got !== want) begin
            $display("[ERROR] ctrl.wb_sel got 0x%01h expected 0x%01h", got, want);
            note_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] ctrl.%s got 0x%01h expected 0x%01h", name, got, want);
            note_error();
        end
    endtask

    task automatic finish_test(input string name);
        if (test_ok) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic check_vector(input int idx);
        ctrl_bundle_t want;
        want    = vec_exp[idx];
        test_ok = 1'b1;
        if (ctrl_valid !== 1'b1) begin
            $display("ctrl_valid was not high one cycle after vector %0d", idx);
            note_error();
        end
        check_src_a(ctrl.src_a_sel, want.src_a_sel);
        check_src_b(ctrl.src_b_sel, want.src_b_sel);
        check_wb(ctrl.wb_sel, want.wb_sel);
        check_bit("ans_sel", ctrl.ans_sel, want.ans_sel);
        check_ccu(ctrl.ccu_mode, want.ccu_mode);
        check_bit("reg_we", ctrl.reg_we, want.reg_we);
        check_width(ctrl.mem_width, want.mem_width);
        check_bit("mem_we", ctrl.mem_we, want.mem_we);
        check_bit("mem_rd", ctrl.mem_rd, want.mem_rd);
        check_jump(ctrl.jump, want.jump);
        finish_test($sformatf("%0s %08h", vec_tag[idx], vec_instr[idx]));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_vectors();
        int            fd;
        int            code;
        logic [127:0]  tag;
        logic [1023:0] rest;
        logic [31:0]   f_instr, f_ccu, f_ans, f_a, f_b, f_wb;
        logic [31:0]   f_rwe, f_mwe, f_mrd, f_width, f_jump;
        ctrl_bundle_t  want;
        fd = $fopen("sim/decode_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/decode_vectors.txt");
            note_error();
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag[127:8] == '0 && tag[7:0] == 8'h23) begin  // Comment line
                code = $fgets(rest, fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_instr, f_ccu, f_ans,
                           f_a, f_b, f_wb, f_rwe, f_mwe, f_mrd, f_width, f_jump);
            if (code != 11) begin
                $display("Vector %0s has missing or unreadable fields", tag);
                note_error();
                break;
            end
            want.src_a_sel = src_a_sel_e'(f_a[2:0]);
            want.src_b_sel = src_b_sel_e'(f_b[2:0]);
            want.wb_sel    = wb_sel_e'(f_wb[2:0]);
            want.ans_sel   = f_ans[0];
            want.ccu_mode  = ccu_mode_e'(f_ccu[7:0]);
            want.reg_we    = f_rwe[0];
            want.mem_width = mem_width_e'(f_width[2:0]);
            want.mem_we    = f_mwe[0];
            want.mem_rd    = f_mrd[0];
            want.jump      = jump_e'(f_jump[3:0]);
            vec_tag.push_back(tag);
            vec_instr.push_back(f_instr);
            vec_exp.push_back(want);
        end
        $fclose(fd);
        if (vec_instr.size() == 0) begin
            $display("No test vectors were read");
            note_error();
        end
    endtask

    initial begin
        int i;
        reset          = 1'b1;
        instr_valid    = 1'b1;          // Reset must win over a valid word
        instr          = 32'h00000013;  // addi x0, x0, 0
        error_count    = 0;
        pass_count     = 0;
        fail_count     = 0;
        test_ok        = 1'b1;
        vectors_loaded = 1'b0;
        lcg_state      = 32'd65;

        load_vectors();
        vec_count      = vec_instr.size();
        vectors_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register comes out of reset empty
        test_ok = 1'b1;
        if (ctrl_valid !== 1'b0) begin
            $display("ctrl_valid was high right after reset");
            note_error();
        end
        if (ctrl !== '0) begin
            $display("[ERROR] ctrl got 0x%h expected 0x0", ctrl);
            note_error();
        end
        finish_test("reset");

        // One vector per cycle back to back
        for (i = 0; i < vec_count; i++) begin
            instr_valid = 1'b1;
            instr       = vec_instr[i];
            pending.push_back(i);
            @(posedge clk);
            #1;
            check_vector(pending.pop_front());
        end

        // Random words on bubbles leave the bundle held
        test_ok = 1'b1;
        for (i = 0; i < idle_cycles; i++) begin
            lcg_state   = lcg_next(lcg_state);
            instr_valid = 1'b0;
            instr       = lcg_state;
            @(posedge clk);
            #1;
            if (ctrl_valid !== 1'b0) begin
                $display("ctrl_valid went high during idle cycle %0d", i);
                note_error();
            end
            if (vec_count > 0 && ctrl !== vec_exp[vec_count - 1]) begin
                $display("[ERROR] ctrl got 0x%h expected 0x%h", ctrl, vec_exp[vec_count - 1]);
                note_error();
            end
        end
        finish_test("idle_random");

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim/decode_vectors.txt
# tag instr ccu_mode ans_sel src_a src_b wb reg_we mem_we mem_rd mem_width jump
# all fields after the tag are hex
r_add     003100b3 01 0 0 0 0 1 0 0 0 0
r_sub     403100b3 00 0 0 0 0 1 0 0 0 0
r_srl     003150b3 05 0 0 0 0 1 0 0 0 0
r_sra     403150b3 07 0 0 0 0 1 0 0 0 0
b_xnor    403140b3 19 0 0 0 0 1 0 0 0 0
b_andn    403170b3 10 0 0 0 0 1 0 0 0 0
b_sh2add  203140b3 17 0 0 0 0 1 0 0 0 0
b_min     0a3140b3 13 0 0 0 0 1 0 0 0 0
b_maxu    0a3170b3 12 0 0 0 0 1 0 0 0 0
b_rol     603110b3 37 0 0 0 0 1 0 0 0 0
r_unlist  403110b3 01 0 0 0 0 1 0 0 0 0
m_mul     023100b3 40 1 0 0 0 1 0 0 0 0
m_divu    023150b3 45 1 0 0 0 1 0 0 0 0
m_remu    023170b3 47 1 0 0 0 1 0 0 0 0
i_srli    00315093 05 0 0 1 0 1 0 0 0 0
i_srai    40315093 07 0 0 1 0 1 0 0 0 0
i_clz     60011093 34 0 0 1 0 1 0 0 0 0
i_ctz     60111093 36 0 0 1 0 1 0 0 0 0
i_cpop    60211093 35 0 0 1 0 1 0 0 0 0
i_rori    60415093 3a 0 0 1 0 1 0 0 0 0
i_unlist  60311093 01 0 0 1 0 1 0 0 0 0
br_blt    00314063 00 0 0 0 0 0 0 0 0 4
br_bgeu   00317063 00 0 0 0 0 0 0 0 0 7
br_f3_2   00312063 00 0 0 0 0 0 0 0 0 3
br_f3_3   00313063 00 0 0 0 0 0 0 0 0 3
ld_lb     00810083 01 0 0 1 2 1 0 1 3 0
ld_lhu    00815083 01 0 0 1 2 1 0 1 2 0
st_sw     00312023 01 0 0 1 0 0 1 0 0 0
j_jal     000000ef 01 0 0 0 1 1 0 0 0 1
j_jalr    000100e7 01 0 0 1 1 1 0 0 0 8
u_auipc   12345097 01 0 1 1 0 1 0 0 0 0
u_lui     123450b7 01 0 2 1 0 1 0 0 0 0
x_zero    00000000 01 0 0 0 0 0 0 0 0 0
x_unknown ffffffff 01 0 0 0 0 0 0 0 0 0

// File: source/alu_op_decoder.sv
`timescale 1ns/1ps

module alu_op_decoder import rv_decode_pkg::*; (
    input  funct7_t    funct7,
    input  funct3_t    funct3,
    input  logic [4:0] rs2_field,
    input  logic       is_imm,
    input  logic       alu_field_en,
    input  logic       is_branch,
    output ccu_mode_e  ccu_mode,
    output logic       ans_sel
);

    // Base RV32I table shared by register and immediate forms
    function automatic ccu_mode_e base_op(input funct3_t f3, input logic arith_shift);
        ccu_mode_e op;
        case (f3)
            3'd0:    op = ccu_add;
            3'd1:    op = ccu_sll;
            3'd2:    op = ccu_slt;
            3'd3:    op = ccu_sltu;
            3'd4:    op = ccu_xor;
            3'd5:    op = arith_shift ? ccu_sra : ccu_srl;
            3'd6:    op = ccu_or;
            default: op = ccu_and;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Register form
    ////////////////////////////////////////////////////////////////////////////

    ccu_mode_e reg_mode;
    logic      reg_md;     // M extension hit

    always_comb begin
        reg_mode = ccu_add;
        reg_md   = 1'b0;

        case (funct7)
            7'h00: reg_mode = base_op(funct3, 1'b0);

            7'h20: begin
                case (funct3)
                    3'd0:    reg_mode = ccu_sub;
                    3'd4:    reg_mode = ccu_xnor;
                    3'd5:    reg_mode = ccu_sra;
                    3'd6:    reg_mode = ccu_orn;
                    3'd7:    reg_mode = ccu_andn;
                    default: reg_mode = ccu_add;
                endcase
            end

            7'h10: begin  // Shift-and-add
                case (funct3)
                    3'd2:    reg_mode = ccu_sh1add;
                    3'd4:    reg_mode = ccu_sh2add;
                    3'd6:    reg_mode = ccu_sh3add;
                    default: reg_mode = ccu_add;
                endcase
            end

            7'h05: begin  // Min / max
                case (funct3)
                    3'd4:    reg_mode = ccu_min;
                    3'd5:    reg_mode = ccu_minu;
                    3'd6:    reg_mode = ccu_max;
                    3'd7:    reg_mode = ccu_maxu;
                    default: reg_mode = ccu_add;
                endcase
            end

            7'h30: begin  // Rotates
                case (funct3)
                    3'd1:    reg_mode = ccu_rol;
                    3'd5:    reg_mode = ccu_ror;
                    default: reg_mode = ccu_add;
                endcase
            end

            7'h01: begin
                reg_md = 1'b1;
                // mul .. remu follow funct3 directly
                reg_mode = ccu_mode_e'({5'b01000, funct3});
            end

            default: reg_mode = ccu_add;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Immediate form
    ////////////////////////////////////////////////////////////////////////////

    ccu_mode_e imm_mode;

    always_comb begin
        if (funct7 == 7'h30 && funct3 == 3'd1) begin
            case (rs2_field)  // Count ops, rs2 picks which
                5'd0:    imm_mode = ccu_clz;
                5'd1:    imm_mode = ccu_ctz;
                5'd2:    imm_mode = ccu_cpop;
                default: imm_mode = ccu_add;
            endcase
        end else if (funct7 == 7'h30 && funct3 == 3'd5) begin
            imm_mode = ccu_rori;
        end else begin
            // srai when any of imm[11:6] is set
            imm_mode = base_op(funct3, |funct7[6:1]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!alu_field_en) begin
            ccu_mode = is_branch ? ccu_sub : ccu_add;  // Compare or address add
            ans_sel  = 1'b0;
        end else if (is_imm) begin
            ccu_mode = imm_mode;
            ans_sel  = 1'b0;
        end else begin
            ccu_mode = reg_mode;
            ans_sel  = reg_md;
        end
    end

endmodule

// File: source/branch_load_decoder.sv
`timescale 1ns/1ps

module branch_load_decoder import rv_decode_pkg::*; (
    input  funct3_t    funct3,
    input  logic [1:0] f3_use,
    input  jump_e      class_jump,
    output jump_e      jump,
    output mem_width_e mem_width
);

    always_comb begin
        jump      = class_jump;
        mem_width = mem_word;  // Stores stay at word width

        if (f3_use == f3_branch) begin
            case (funct3)
                3'd0:    jump = jump_eq;   // beq
                3'd1:    jump = jump_neq;  // bne
                3'd4:    jump = jump_slt;  // blt
                3'd5:    jump = jump_sgt;  // bge
                3'd6:    jump = jump_ult;  // bltu
                3'd7:    jump = jump_ugt;  // bgeu
                default: jump = jump_eq;
            endcase
        end else if (f3_use == f3_load) begin
            case (funct3)
                3'd0:    mem_width = mem_byte;
                3'd1:    mem_width = mem_half;
                3'd2:    mem_width = mem_word;
                3'd4:    mem_width = mem_byte_u;
                3'd5:    mem_width = mem_half_u;
                default: mem_width = mem_word;
            endcase
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_decode_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         instr_valid,
    input  instr_t       instr,
    output logic         ctrl_valid,
    output ctrl_bundle_t ctrl
);

    // Instruction fields
    opcode_t    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    logic [4:0] rs2_field;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rs2_field = instr[24:20];
    assign funct7    = instr[31:25];

    src_a_sel_e   src_a_sel;
    src_b_sel_e   src_b_sel;
    wb_sel_e      wb_sel;
    logic         reg_we;
    logic         mem_we;
    logic         mem_rd;
    logic         alu_field_en;
    logic         is_imm;
    logic         is_branch;
    jump_e        class_jump;
    logic [1:0]   f3_use;
    ccu_mode_e    ccu_mode;
    logic         ans_sel;
    jump_e        jump;
    mem_width_e   mem_width;
    ctrl_bundle_t ctrl_next;

    opcode_class_decoder u_class (
        .opcode       (opcode),
        .src_a_sel    (src_a_sel),
        .src_b_sel    (src_b_sel),
        .wb_sel       (wb_sel),
        .reg_we       (reg_we),
        .mem_we       (mem_we),
        .mem_rd       (mem_rd),
        .alu_field_en (alu_field_en),
        .is_imm       (is_imm),
        .class_jump   (class_jump),
        .f3_use       (f3_use)
    );

    assign is_branch = (f3_use == f3_branch);

    alu_op_decoder u_alu_op (
        .funct7       (funct7),
        .funct3       (funct3),
        .rs2_field    (rs2_field),
        .is_imm       (is_imm),
        .alu_field_en (alu_field_en),
        .is_branch    (is_branch),
        .ccu_mode     (ccu_mode),
        .ans_sel      (ans_sel)
    );

    branch_load_decoder u_br_ld (
        .funct3     (funct3),
        .f3_use     (f3_use),
        .class_jump (class_jump),
        .jump       (jump),
        .mem_width  (mem_width)
    );

    always_comb begin
        ctrl_next.src_a_sel = src_a_sel;
        ctrl_next.src_b_sel = src_b_sel;
        ctrl_next.wb_sel    = wb_sel;
        ctrl_next.ans_sel   = ans_sel;
        ctrl_next.ccu_mode  = ccu_mode;
        ctrl_next.reg_we    = reg_we;
        ctrl_next.mem_width = mem_width;
        ctrl_next.mem_we    = mem_we;
        ctrl_next.mem_rd    = mem_rd;
        ctrl_next.jump      = jump;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_valid <= 1'b0;
            ctrl       <= '0;
        end else begin
            ctrl_valid <= instr_valid;
            if (instr_valid) begin
                ctrl <= ctrl_next;  // Hold last bundle on bubbles
            end
        end
    end

endmodule

// File: source/opcode_class_decoder.sv
`timescale 1ns/1ps

module opcode_class_decoder import rv_decode_pkg::*; (
    input  opcode_t    opcode,
    output src_a_sel_e src_a_sel,
    output src_b_sel_e src_b_sel,
    output wb_sel_e    wb_sel,
    output logic       reg_we,
    output logic       mem_we,
    output logic       mem_rd,
    output logic       alu_field_en,
    output logic       is_imm,
    output jump_e      class_jump,
    output logic [1:0] f3_use
);

    always_comb begin
        // Bubble unless the opcode says otherwise
        src_a_sel    = src_a_reg;
        src_b_sel    = src_b_reg;
        wb_sel       = wb_alu;
        reg_we       = 1'b0;
        mem_we       = 1'b0;
        mem_rd       = 1'b0;
        alu_field_en = 1'b0;
        is_imm       = 1'b0;
        class_jump   = jump_npc;
        f3_use       = f3_none;

        case (opcode)
            op_arith_r: begin
                reg_we       = 1'b1;
                alu_field_en = 1'b1;
            end

            op_arith_i: begin
                src_b_sel    = src_b_imm;
                reg_we       = 1'b1;
                alu_field_en = 1'b1;
                is_imm       = 1'b1;
            end

            op_branch: begin
                f3_use = f3_branch;  // Condition comes from funct3
            end

            op_load: begin
                src_b_sel = src_b_imm;
                wb_sel    = wb_mem;
                reg_we    = 1'b1;
                mem_rd    = 1'b1;
                f3_use    = f3_load;
            end

            op_store: begin
                src_b_sel = src_b_imm;  // Address is rs1 + imm
                mem_we    = 1'b1;
            end

            op_jal: begin
                wb_sel     = wb_link;
                reg_we     = 1'b1;
                class_jump = jump_offpc;
            end

            op_jalr: begin
                src_b_sel  = src_b_imm;
                wb_sel     = wb_link;
                reg_we     = 1'b1;
                class_jump = jump_jalr;
            end

            op_auipc: begin
                src_a_sel = src_a_pc;
                src_b_sel = src_b_imm;
                reg_we    = 1'b1;
            end

            op_lui: begin
                src_a_sel = src_a_zero;  // 0 + imm
                src_b_sel = src_b_imm;
                reg_we    = 1'b1;
            end

            op_system: begin
                // CSR access not supported, keep the bubble
            end

            default: begin
            end
        endcase
    end

endmodule

// File: source/rv_decode_pkg.sv
package rv_decode_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Integer major opcodes handled by the core
    typedef enum logic [6:0] {
        op_arith_r = 7'b0110011,  // R-type, I/B/M
        op_arith_i = 7'b0010011,  // I-type arithmetic
        op_branch  = 7'b1100011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_auipc   = 7'b0010111,
        op_lui     = 7'b0110111,
        op_system  = 7'b1110011   // CSR, decoded as a bubble
    } opcode_e;

    // What funct3 means for the current opcode class
    localparam logic [1:0] f3_none   = 2'd0;
    localparam logic [1:0] f3_branch = 2'd1;
    localparam logic [1:0] f3_load   = 2'd2;

    ////////////////////////////////////////////////////////////////////////////
    // Compute unit modes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        // Base integer ALU
        ccu_sub    = 8'h00,
        ccu_add    = 8'h01,
        ccu_and    = 8'h02,
        ccu_or     = 8'h03,
        ccu_xor    = 8'h04,
        ccu_srl    = 8'h05,
        ccu_sll    = 8'h06,
        ccu_sra    = 8'h07,
        ccu_slt    = 8'h08,
        ccu_sltu   = 8'h09,
        // Bit-manip ALU ops
        ccu_andn   = 8'h10,
        ccu_max    = 8'h11,
        ccu_maxu   = 8'h12,
        ccu_min    = 8'h13,
        ccu_minu   = 8'h14,
        ccu_orn    = 8'h15,
        ccu_sh1add = 8'h16,
        ccu_sh2add = 8'h17,
        ccu_sh3add = 8'h18,
        ccu_xnor   = 8'h19,
        // Bit count and rotate unit
        ccu_clz    = 8'h34,
        ccu_cpop   = 8'h35,
        ccu_ctz    = 8'h36,
        ccu_rol    = 8'h37,
        ccu_ror    = 8'h38,
        ccu_roli   = 8'h39,
        ccu_rori   = 8'h3A,
        // Multiply / divide unit
        ccu_mul    = 8'h40,
        ccu_mulh   = 8'h41,
        ccu_mulhsu = 8'h42,
        ccu_mulhu  = 8'h43,
        ccu_div    = 8'h44,
        ccu_divu   = 8'h45,
        ccu_rem    = 8'h46,
        ccu_remu   = 8'h47
    } ccu_mode_e;

    ////////////////////////////////////////////////////////////////////////////
    // Next-PC, memory and mux selects
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        jump_npc   = 4'h0,  // pc + 4
        jump_offpc = 4'h1,  // pc + imm
        jump_neq   = 4'h2,
        jump_eq    = 4'h3,
        jump_slt   = 4'h4,
        jump_ult   = 4'h5,
        jump_sgt   = 4'h6,
        jump_ugt   = 4'h7,
        jump_jalr  = 4'h8   // rs1 + imm
    } jump_e;

    typedef enum logic [2:0] {
        mem_word   = 3'h0,
        mem_half   = 3'h1,
        mem_half_u = 3'h2,
        mem_byte   = 3'h3,
        mem_byte_u = 3'h4
    } mem_width_e;

    typedef enum logic [2:0] {
        src_a_reg  = 3'h0,
        src_a_pc   = 3'h1,
        src_a_zero = 3'h2
    } src_a_sel_e;

    typedef enum logic [2:0] {
        src_b_reg = 3'h0,
        src_b_imm = 3'h1
    } src_b_sel_e;

    typedef enum logic [2:0] {
        wb_alu  = 3'h0,
        wb_link = 3'h1,
        wb_mem  = 3'h2
    } wb_sel_e;

    // Everything the execute stage needs for one instruction
    typedef struct packed {
        src_a_sel_e src_a_sel;
        src_b_sel_e src_b_sel;
        wb_sel_e    wb_sel;
        logic       ans_sel;    // Take mul/div result
        ccu_mode_e  ccu_mode;
        logic       reg_we;
        mem_width_e mem_width;
        logic       mem_we;
        logic       mem_rd;
        jump_e      jump;
    } ctrl_bundle_t;

endpackage

// File: src.f
source/rv_decode_pkg.sv
source/opcode_class_decoder.sv
source/alu_op_decoder.sv
source/branch_load_decoder.sv
source/decode_stage.sv
sim/decode_stage_chk.sv
sim/decode_stage_tb.sv
